/* slap_video_pkg.sv */
// slap fight video package
// screen timing, AXI4-Lite register map and the types shared by the video units
package slap_video_pkg;

	//============================================================
	// screen timing, raw counter values
	//============================================================
	localparam int unsigned H_TOTAL     = 384;  // pixels per line
	localparam int unsigned H_VIS_FIRST = 13;
	localparam int unsigned H_VIS_LAST  = 268;
	localparam int unsigned HSYNC_FIRST = 300;
	localparam int unsigned HSYNC_LAST  = 331;

	localparam int unsigned V_TOTAL     = 264;  // lines per frame
	localparam int unsigned V_VIS_FIRST = 16;
	localparam int unsigned V_VIS_LAST  = 239;
	localparam int unsigned VSYNC_FIRST = 248;
	localparam int unsigned VSYNC_LAST  = 251;

	localparam int unsigned HPOS_W      = 9;
	localparam int unsigned VPOS_W      = 8;
	localparam int unsigned LINE_W      = 9;    // raw line count reaches 263
	localparam int unsigned COLOR_IDX_W = 8;
	localparam int unsigned PAL_DEPTH   = 1 << COLOR_IDX_W;

	//============================================================
	// AXI4-Lite register map
	//============================================================
	localparam int unsigned AXI_ADDR_W = 12;
	localparam int unsigned AXI_DATA_W = 32;

	localparam logic [AXI_ADDR_W-1:0] REG_HSCROLL = 12'h000;
	localparam logic [AXI_ADDR_W-1:0] REG_VSCROLL = 12'h004;
	localparam logic [AXI_ADDR_W-1:0] REG_CTRL    = 12'h008;
	localparam logic [AXI_ADDR_W-1:0] PAL_BASE    = 12'h400;  // entry n at +4n

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	//============================================================
	// types
	//============================================================
	typedef struct packed {
		logic [HPOS_W-1:0] h;
		logic [VPOS_W-1:0] v;
	} screen_pos_t;

	typedef struct packed {
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
	} rgb_t;

	typedef struct packed {
		logic [HPOS_W-1:0] hscroll;
		logic [VPOS_W-1:0] vscroll;
		logic              flip;
	} scroll_cfg_t;

	// scroll and control registers, value in the low bits, flip is bit 0
	typedef struct packed {
		logic [AXI_DATA_W-HPOS_W-1:0] rsvd;
		logic [HPOS_W-1:0]            value;
	} ctrl_word_t;

	typedef struct packed {
		logic [AXI_DATA_W-$bits(rgb_t)-1:0] rsvd;
		rgb_t                               rgb;
	} pal_word_t;

	typedef union packed {
		ctrl_word_t ctrl;
		pal_word_t  pal;
	} reg_word_u;

	typedef struct packed {
		logic [COLOR_IDX_W-1:0] fg;
		logic [COLOR_IDX_W-1:0] sp;
		logic [COLOR_IDX_W-1:0] bg;
	} layer_pix_t;

	typedef struct packed {
		logic [AXI_ADDR_W-1:0] awaddr;
		logic                  awvalid;
		logic [AXI_DATA_W-1:0] wdata;
		logic                  wvalid;
		logic                  bready;
		logic [AXI_ADDR_W-1:0] araddr;
		logic                  arvalid;
		logic                  rready;
	} axil_req_t;

	typedef struct packed {
		logic                  awready;
		logic                  wready;
		logic                  bvalid;
		logic [1:0]            bresp;
		logic                  arready;
		logic                  rvalid;
		logic [AXI_DATA_W-1:0] rdata;
		logic [1:0]            rresp;
	} axil_rsp_t;

endpackage

/* slap_video_regs.sv */
// video register block
// AXI4-Lite slave for the scroll and flip registers and the palette write port
`timescale 1ns/1ps

module slap_video_regs (
	input  logic                                   pixel_clk,
	input  logic                                   RESET_n,
	input  slap_video_pkg::axil_req_t              axil_i,
	input  logic                                   frame_start_i,
	output slap_video_pkg::axil_rsp_t              axil_o,
	output slap_video_pkg::scroll_cfg_t            cfg_o,
	output logic                                   pal_we_o,
	output logic [slap_video_pkg::COLOR_IDX_W-1:0] pal_idx_o,
	output slap_video_pkg::rgb_t                   pal_rgb_o
);
	import slap_video_pkg::*;

	reg_word_u             wdata_u;
	scroll_cfg_t           staged_q;   // cpu side copy
	scroll_cfg_t           active_q;   // what the counters see
	logic                  busy;
	logic                  wr_accept;
	logic                  rd_accept;
	logic                  wr_is_reg;
	logic                  wr_is_pal;
	logic                  bvalid_q;
	logic [1:0]            bresp_q;
	logic                  rvalid_q;
	logic [1:0]            rresp_q;
	logic [AXI_DATA_W-1:0] rdata_q;
	logic [AXI_DATA_W-1:0] rd_data;
	logic [1:0]            rd_resp;

	//============================================================
	// handshake and address decode
	//============================================================
	assign wdata_u   = axil_i.wdata;
	assign busy      = bvalid_q | rvalid_q;  // one transaction at a time
	assign wr_accept = axil_i.awvalid & axil_i.wvalid & ~busy;
	assign rd_accept = axil_i.arvalid & ~busy & ~wr_accept;  // write wins a tie

	assign wr_is_reg = axil_i.awaddr inside {REG_HSCROLL, REG_VSCROLL, REG_CTRL};
	assign wr_is_pal = (axil_i.awaddr[AXI_ADDR_W-1:COLOR_IDX_W+2] ==
		PAL_BASE[AXI_ADDR_W-1:COLOR_IDX_W+2]) && (axil_i.awaddr[1:0] == 2'b00);

	// palette write goes straight through to the compositor RAM
	assign pal_we_o  = wr_accept & wr_is_pal;
	assign pal_idx_o = axil_i.awaddr[COLOR_IDX_W+1:2];
	assign pal_rgb_o = wdata_u.pal.rgb;

	//============================================================
	// scroll and flip registers
	//============================================================
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			staged_q <= '0;
			active_q <= '0;
		end else begin
			if (wr_accept) begin
				case (axil_i.awaddr)
					REG_HSCROLL: staged_q.hscroll <= wdata_u.ctrl.value;
					REG_VSCROLL: staged_q.vscroll <= wdata_u.ctrl.value[VPOS_W-1:0];
					REG_CTRL:    staged_q.flip    <= wdata_u.ctrl.value[0];
					default: ;
				endcase
			end
			if (frame_start_i)
				active_q <= staged_q;  // new values only from the top of a frame
		end
	end

	assign cfg_o = active_q;

	// read mux, palette is write only
	always_comb begin
		rd_data = '0;
		rd_resp = RESP_OKAY;
		case (axil_i.araddr)
			REG_HSCROLL: rd_data = AXI_DATA_W'(staged_q.hscroll);
			REG_VSCROLL: rd_data = AXI_DATA_W'(staged_q.vscroll);
			REG_CTRL:    rd_data = AXI_DATA_W'(staged_q.flip);
			default:     rd_resp = RESP_SLVERR;
		endcase
	end

	//============================================================
	// response channels
	//============================================================
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			bvalid_q <= 1'b0;
			bresp_q  <= RESP_OKAY;
		end else if (wr_accept) begin
			bvalid_q <= 1'b1;
			bresp_q  <= (wr_is_reg | wr_is_pal) ? RESP_OKAY : RESP_SLVERR;
		end else if (axil_i.bready) begin
			bvalid_q <= 1'b0;
		end
	end

	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			rvalid_q <= 1'b0;
			rresp_q  <= RESP_OKAY;
		end else if (rd_accept) begin
			rvalid_q <= 1'b1;
			rresp_q  <= rd_resp;
		end else if (axil_i.rready) begin
			rvalid_q <= 1'b0;
		end
	end

	always_ff @(posedge pixel_clk) begin
		if (rd_accept)
			rdata_q <= rd_data;
	end

	always_comb begin
		axil_o.awready = wr_accept;
		axil_o.wready  = wr_accept;
		axil_o.bvalid  = bvalid_q;
		axil_o.bresp   = bresp_q;
		axil_o.arready = rd_accept;
		axil_o.rvalid  = rvalid_q;
		axil_o.rdata   = rdata_q;
		axil_o.rresp   = rresp_q;
	end

	// response must sit unchanged until the master takes it
	assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		bvalid_q && !axil_i.bready |=> bvalid_q && $stable(bresp_q));

endmodule

/* slap_h_timing.sv */
// horizontal timing unit
// pixel counter with screen flip, line sync, blanking and scrolled column
`timescale 1ns/1ps

module slap_h_timing (
	input  logic                              pixel_clk,
	input  logic                              RESET_n,
	input  slap_video_pkg::scroll_cfg_t       cfg_i,
	output logic [slap_video_pkg::HPOS_W-1:0] h_o,
	output logic [slap_video_pkg::HPOS_W-1:0] hscroll_o,
	output logic                              line_end_o,
	output logic                              hsync_o,
	output logic                              hblank_o
);
	import slap_video_pkg::*;

	logic [HPOS_W-1:0] hcnt_q;  // raw column
	logic [HPOS_W-1:0] h_scr;

	assign line_end_o = (hcnt_q == HPOS_W'(H_TOTAL - 1));

	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n)
			hcnt_q <= '0;
		else if (line_end_o)
			hcnt_q <= '0;
		else
			hcnt_q <= hcnt_q + 1'b1;
	end

	//============================================================
	// outputs, decoded from the count register
	//============================================================
	// flipped screen runs the column backwards like the old down counter
	assign h_scr = cfg_i.flip ? HPOS_W'(H_TOTAL - 1) - hcnt_q : hcnt_q;

	assign h_o       = h_scr;
	assign hscroll_o = h_scr + cfg_i.hscroll;  // wraps at 512

	// sync and blank stay on the raw column
	assign hsync_o  = (hcnt_q >= HPOS_W'(HSYNC_FIRST)) && (hcnt_q <= HPOS_W'(HSYNC_LAST));
	assign hblank_o = (hcnt_q < HPOS_W'(H_VIS_FIRST)) || (hcnt_q > HPOS_W'(H_VIS_LAST));

	// counter never passes the end of line
	assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		hcnt_q < HPOS_W'(H_TOTAL));

endmodule

/* slap_v_timing.sv */
// vertical timing unit
// line counter with screen flip, frame sync, blanking and scrolled line
`timescale 1ns/1ps

module slap_v_timing (
	input  logic                              pixel_clk,
	input  logic                              RESET_n,
	input  logic                              line_end_i,
	input  slap_video_pkg::scroll_cfg_t       cfg_i,
	output logic [slap_video_pkg::VPOS_W-1:0] v_o,
	output logic [slap_video_pkg::VPOS_W-1:0] vscroll_o,
	output logic                              frame_start_o,
	output logic                              vsync_o,
	output logic                              vblank_o
);
	import slap_video_pkg::*;

	logic [LINE_W-1:0] vcnt_q;  // raw line
	logic              last_line;
	logic [VPOS_W-1:0] v_scr;

	assign last_line     = (vcnt_q == LINE_W'(V_TOTAL - 1));
	assign frame_start_o = line_end_i & last_line;

	// steps once per line
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n)
			vcnt_q <= '0;
		else if (line_end_i)
			vcnt_q <= last_line ? '0 : vcnt_q + 1'b1;
	end

	//============================================================
	// outputs
	//============================================================
	// flip inverts the low byte only, as the board did
	assign v_scr = cfg_i.flip ? ~vcnt_q[VPOS_W-1:0] : vcnt_q[VPOS_W-1:0];

	assign v_o       = v_scr;
	assign vscroll_o = v_scr + cfg_i.vscroll;  // wraps at 256

	assign vsync_o  = (vcnt_q >= LINE_W'(VSYNC_FIRST)) && (vcnt_q <= LINE_W'(VSYNC_LAST));
	assign vblank_o = (vcnt_q < LINE_W'(V_VIS_FIRST)) || (vcnt_q > LINE_W'(V_VIS_LAST));

	// frame start sits on the last column of the last line, then both counters restart
	assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		frame_start_o |-> line_end_i ##1 (vcnt_q == '0));

endmodule

/* slap_compositor.sv */
// pixel compositor
// picks foreground, sprite or background by priority, then palette lookup and blanking
`timescale 1ns/1ps

module slap_compositor (
	input  logic                                   pixel_clk,
	input  logic                                   RESET_n,
	input  slap_video_pkg::layer_pix_t             layers_i,
	input  logic                                   hblank_i,
	input  logic                                   vblank_i,
	input  logic                                   pal_we_i,
	input  logic [slap_video_pkg::COLOR_IDX_W-1:0] pal_idx_i,
	input  slap_video_pkg::rgb_t                   pal_rgb_i,
	output slap_video_pkg::rgb_t                   rgb_o,
	output logic                                   hblank_o,
	output logic                                   vblank_o
);
	import slap_video_pkg::*;

	rgb_t                   pal_mem [PAL_DEPTH];
	logic [COLOR_IDX_W-1:0] color_idx;
	logic [COLOR_IDX_W-1:0] color_q;   // stage 1
	rgb_t                   pal_q;     // stage 2
	logic [1:0]             hblank_q;  // one bit per stage
	logic [1:0]             vblank_q;

	//============================================================
	// stage 1, layer priority
	//============================================================
	always_comb begin
		if (layers_i.fg[1:0] != 2'b00)
			color_idx = layers_i.fg;  // text over everything
		else if (layers_i.sp[3:0] != 4'h0)
			color_idx = layers_i.sp;
		else
			color_idx = layers_i.bg;
	end

	always_ff @(posedge pixel_clk) begin
		color_q <= color_idx;
	end

	//============================================================
	// stage 2, palette RAM
	//============================================================
	always_ff @(posedge pixel_clk) begin
		if (pal_we_i)
			pal_mem[pal_idx_i] <= pal_rgb_i;  // bus write port
		pal_q <= pal_mem[color_q];
	end

	// blank flags ride along with the pixel, blanked out of reset
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			hblank_q <= '1;
			vblank_q <= '1;
		end else begin
			hblank_q <= {hblank_q[0], hblank_i};
			vblank_q <= {vblank_q[0], vblank_i};
		end
	end

	assign hblank_o = hblank_q[1];
	assign vblank_o = vblank_q[1];
	assign rgb_o    = (hblank_q[1] | vblank_q[1]) ? '0 : pal_q;

endmodule

/* slap_video_top.sv */
// slap fight video top level
// joins the timing units, register block and compositor
`timescale 1ns/1ps

module slap_video_top (
	input  logic                        pixel_clk,
	input  logic                        RESET_n,
	input  slap_video_pkg::axil_req_t   axil_i,
	output slap_video_pkg::axil_rsp_t   axil_o,
	input  slap_video_pkg::layer_pix_t  layers_i,
	output slap_video_pkg::screen_pos_t pos_o,
	output slap_video_pkg::screen_pos_t scroll_pos_o,
	output logic                        hsync_o,
	output logic                        vsync_o,
	output slap_video_pkg::rgb_t        rgb_o,
	output logic                        hblank_o,
	output logic                        vblank_o
);
	import slap_video_pkg::*;

	scroll_cfg_t            active_cfg;
	logic                   line_end;
	logic                   frame_start;
	logic                   hblank;
	logic                   vblank;
	logic                   pal_we;
	logic [COLOR_IDX_W-1:0] pal_idx;
	rgb_t                   pal_rgb;
	logic [HPOS_W-1:0]      h_pos;
	logic [HPOS_W-1:0]      h_scroll;
	logic [VPOS_W-1:0]      v_pos;
	logic [VPOS_W-1:0]      v_scroll;

	assign pos_o        = '{h: h_pos, v: v_pos};
	assign scroll_pos_o = '{h: h_scroll, v: v_scroll};  // background fetch position

	slap_video_regs i_regs (
		.pixel_clk     (pixel_clk),
		.RESET_n       (RESET_n),
		.axil_i        (axil_i),
		.frame_start_i (frame_start),
		.axil_o        (axil_o),
		.cfg_o         (active_cfg),
		.pal_we_o      (pal_we),
		.pal_idx_o     (pal_idx),
		.pal_rgb_o     (pal_rgb)
	);

	slap_h_timing i_h_timing (
		.pixel_clk  (pixel_clk),
		.RESET_n    (RESET_n),
		.cfg_i      (active_cfg),
		.h_o        (h_pos),
		.hscroll_o  (h_scroll),
		.line_end_o (line_end),
		.hsync_o    (hsync_o),
		.hblank_o   (hblank)
	);

	slap_v_timing i_v_timing (
		.pixel_clk     (pixel_clk),
		.RESET_n       (RESET_n),
		.line_end_i    (line_end),
		.cfg_i         (active_cfg),
		.v_o           (v_pos),
		.vscroll_o     (v_scroll),
		.frame_start_o (frame_start),
		.vsync_o       (vsync_o),
		.vblank_o      (vblank)
	);

	slap_compositor i_compositor (
		.pixel_clk (pixel_clk),
		.RESET_n   (RESET_n),
		.layers_i  (layers_i),
		.hblank_i  (hblank),
		.vblank_i  (vblank),
		.pal_we_i  (pal_we),
		.pal_idx_i (pal_idx),
		.pal_rgb_i (pal_rgb),
		.rgb_o     (rgb_o),
		.hblank_o  (hblank_o),
		.vblank_o  (vblank_o)
	);

endmodule

/* tb_slap_video.sv */
// slap fight video testbench
// drives AXI4-Lite and layer pixels, checks timing, scroll, flip and colour output
`timescale 1ns/1ps

module tb_slap_video;
	import slap_video_pkg::*;

	localparam int unsigned AXI_TIMEOUT   = 32;
	localparam int unsigned FRAME_TIMEOUT = 2 * H_TOTAL * V_TOTAL;
	localparam logic [31:0] RNG_SEED      = 32'h54df;

	logic        pixel_clk;
	logic        RESET_n;
	axil_req_t   axil_req;
	axil_rsp_t   axil_rsp;
	layer_pix_t  layers = '0;
	screen_pos_t pos;
	screen_pos_t scroll_pos;
	logic        hsync;
	logic        vsync;
	rgb_t        rgb;
	logic        hblank;
	logic        vblank;

	int unsigned col;        // raw column, tracked from reset
	int unsigned line;       // raw line
	scroll_cfg_t exp_cfg;    // config the counters should be using
	rgb_t        pal_model [PAL_DEPTH];
	logic        pal_ready;  // every entry written
	logic [31:0] pal_rng;
	logic [31:0] layer_rng = RNG_SEED;
	layer_pix_t  pix_d [2];  // layer pipeline, [1] is two cycles old
	logic [1:0]  hb_d;
	logic [1:0]  vb_d;
	int unsigned pipe_fill;

	slap_video_top i_slap_video_top (
		.pixel_clk    (pixel_clk),
		.RESET_n      (RESET_n),
		.axil_i       (axil_req),
		.axil_o       (axil_rsp),
		.layers_i     (layers),
		.pos_o        (pos),
		.scroll_pos_o (scroll_pos),
		.hsync_o      (hsync),
		.vsync_o      (vsync),
		.rgb_o        (rgb),
		.hblank_o     (hblank),
		.vblank_o     (vblank)
	);

	initial begin
		pixel_clk = 1'b0;
		forever #20 pixel_clk = ~pixel_clk;
	end

	//============================================================
	// reference model
	//============================================================
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// fg wins on any of its low 2 bits, then sprite on its low 4 bits
	function automatic rgb_t ref_color(input layer_pix_t px);
		logic [COLOR_IDX_W-1:0] idx;
		if (px.fg[1:0] != 2'b00)
			idx = px.fg;
		else if (px.sp[3:0] != 4'h0)
			idx = px.sp;
		else
			idx = px.bg;
		return pal_model[idx];
	endfunction

	// raw counters step on the same edge as the DUT
	always @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			col  = 0;
			line = 0;
		end else if (col == H_TOTAL - 1) begin
			col  = 0;
			line = (line == V_TOTAL - 1) ? 0 : line + 1;
		end else begin
			col = col + 1;
		end
	end

	always @(posedge pixel_clk) begin
		if (RESET_n) begin
			layer_rng = xorshift32(layer_rng);
			layers <= layer_pix_t'(layer_rng[23:0]);
		end
	end

	//============================================================
	// checks
	//============================================================
	task automatic fail_run();
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic timeout_fail(input string what);
		$display("timeout while waiting for %s", what);
		fail_run();
	endtask

	task automatic check_pos(input string name, input screen_pos_t got, input screen_pos_t exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			fail_run();
		end
	endtask

	task automatic check_rgb(input string name, input rgb_t got, input rgb_t exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			fail_run();
		end
	endtask

	task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			fail_run();
		end
	endtask

	task automatic check_data(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			fail_run();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			fail_run();
		end
	endtask

	// outputs are sampled half a cycle after they change
	always @(negedge pixel_clk) begin
		screen_pos_t exp_pos;
		screen_pos_t exp_scr;
		rgb_t        exp_rgb;
		if (!RESET_n) begin
			pipe_fill = 0;
		end else begin
			exp_pos.h = exp_cfg.flip ? HPOS_W'(H_TOTAL - 1 - col) : HPOS_W'(col);
			exp_pos.v = exp_cfg.flip ? 8'd255 - VPOS_W'(line) : VPOS_W'(line);
			exp_scr.h = exp_pos.h + exp_cfg.hscroll;  // mod 512
			exp_scr.v = exp_pos.v + exp_cfg.vscroll;  // mod 256
			check_pos("pos_o", pos, exp_pos);
			check_pos("scroll_pos_o", scroll_pos, exp_scr);
			check_bit("hsync_o", hsync, (col >= HSYNC_FIRST) && (col <= HSYNC_LAST));
			check_bit("vsync_o", vsync, (line >= VSYNC_FIRST) && (line <= VSYNC_LAST));
			if (pipe_fill < 2) begin
				check_rgb("rgb_o", rgb, '0);  // still blank from reset
			end else begin
				check_bit("hblank_o", hblank, hb_d[1]);
				check_bit("vblank_o", vblank, vb_d[1]);
				if (pal_ready) begin
					exp_rgb = (hb_d[1] | vb_d[1]) ? '0 : ref_color(pix_d[1]);
					check_rgb("rgb_o", rgb, exp_rgb);
				end
			end
			pix_d[1] = pix_d[0];
			pix_d[0] = layers;
			hb_d = {hb_d[0], (col < H_VIS_FIRST) || (col > H_VIS_LAST)};
			vb_d = {vb_d[0], (line < V_VIS_FIRST) || (line > V_VIS_LAST)};
			if (pipe_fill < 2)
				pipe_fill++;
		end
	end

	//============================================================
	// AXI4-Lite master
	//============================================================
	task automatic axi_write(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] data,
		output logic [1:0] resp);
		int unsigned n;
		@(posedge pixel_clk);
		axil_req.awaddr  <= addr;
		axil_req.awvalid <= 1'b1;
		axil_req.wdata   <= data;
		axil_req.wvalid  <= 1'b1;
		n = 0;
		@(negedge pixel_clk);
		while (!(axil_rsp.awready && axil_rsp.wready)) begin
			n++;
			if (n > AXI_TIMEOUT)
				timeout_fail("awready and wready");
			@(negedge pixel_clk);
		end
		@(posedge pixel_clk);  // accept edge
		axil_req.awvalid <= 1'b0;
		axil_req.wvalid  <= 1'b0;
		n = 0;
		@(negedge pixel_clk);
		while (!axil_rsp.bvalid) begin
			n++;
			if (n > AXI_TIMEOUT)
				timeout_fail("bvalid");
			@(negedge pixel_clk);
		end
		// bready comes a cycle late so the response has to hold
		@(posedge pixel_clk);
		axil_req.bready <= 1'b1;
		@(negedge pixel_clk);
		check_bit("bvalid", axil_rsp.bvalid, 1'b1);
		resp = axil_rsp.bresp;
		@(posedge pixel_clk);
		axil_req.bready <= 1'b0;
	endtask

	task automatic axi_read(input logic [AXI_ADDR_W-1:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		int unsigned n;
		@(posedge pixel_clk);
		axil_req.araddr  <= addr;
		axil_req.arvalid <= 1'b1;
		n = 0;
		@(negedge pixel_clk);
		while (!axil_rsp.arready) begin
			n++;
			if (n > AXI_TIMEOUT)
				timeout_fail("arready");
			@(negedge pixel_clk);
		end
		@(posedge pixel_clk);
		axil_req.arvalid <= 1'b0;
		n = 0;
		@(negedge pixel_clk);
		while (!axil_rsp.rvalid) begin
			n++;
			if (n > AXI_TIMEOUT)
				timeout_fail("rvalid");
			@(negedge pixel_clk);
		end
		@(posedge pixel_clk);
		axil_req.rready <= 1'b1;
		@(negedge pixel_clk);
		check_bit("rvalid", axil_rsp.rvalid, 1'b1);
		data = axil_rsp.rdata;
		resp = axil_rsp.rresp;
		@(posedge pixel_clk);
		axil_req.rready <= 1'b0;
	endtask

	task automatic read_and_check(input logic [AXI_ADDR_W-1:0] addr, input logic [1:0] exp_resp,
		input logic [31:0] exp_data);
		logic [31:0] rd;
		logic [1:0]  resp;
		axi_read(addr, rd, resp);
		check_resp("rresp", resp, exp_resp);
		check_data("rdata", rd, exp_data);
	endtask

	task automatic write_and_check(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] data,
		input logic [31:0] exp_data);
		logic [1:0] resp;
		axi_write(addr, data, resp);
		check_resp("bresp", resp, RESP_OKAY);
		read_and_check(addr, RESP_OKAY, exp_data);
	endtask

	// returns just after the edge where the staged config goes live
	task automatic wait_frame_start();
		int unsigned n;
		n = 0;
		@(negedge pixel_clk);
		while (!((col == H_TOTAL - 1) && (line == V_TOTAL - 1))) begin
			n++;
			if (n > FRAME_TIMEOUT)
				timeout_fail("frame start");
			@(negedge pixel_clk);
		end
		@(posedge pixel_clk);
	endtask

	//============================================================
	// test sequence
	//============================================================
	initial begin
		logic [1:0] resp;
		axil_req  <= '0;
		RESET_n   <= 1'b0;
		exp_cfg   = '0;
		pal_ready = 1'b0;
		pal_rng   = RNG_SEED;
		repeat (8) @(posedge pixel_clk);
		RESET_n <= 1'b1;

		for (int i = 0; i < PAL_DEPTH; i++) begin
			pal_rng = xorshift32(pal_rng);
			pal_model[i] = rgb_t'(pal_rng[11:0]);
			axi_write(PAL_BASE + AXI_ADDR_W'(4 * i), pal_rng, resp);
			check_resp("bresp", resp, RESP_OKAY);
		end
		@(posedge pixel_clk);
		pal_ready = 1'b1;

		write_and_check(REG_HSCROLL, 32'hffff_f1a5, 32'h0000_01a5);
		write_and_check(REG_VSCROLL, 32'h1234_5697, 32'h0000_0097);
		write_and_check(REG_CTRL, 32'hffff_fffe, 32'h0000_0000);

		// palette is write only, holes answer with SLVERR
		read_and_check(PAL_BASE + 12'h020, RESP_SLVERR, 32'h0);
		axi_write(12'h00c, 32'hffff_ffff, resp);
		check_resp("bresp", resp, RESP_SLVERR);
		axi_write(12'h402, 32'h0000_0fff, resp);  // misaligned palette slot
		check_resp("bresp", resp, RESP_SLVERR);
		read_and_check(12'h00c, RESP_SLVERR, 32'h0);
		read_and_check(REG_HSCROLL, RESP_OKAY, 32'h0000_01a5);
		read_and_check(REG_VSCROLL, RESP_OKAY, 32'h0000_0097);
		read_and_check(REG_CTRL, RESP_OKAY, 32'h0000_0000);

		wait_frame_start();
		exp_cfg = '{hscroll: 9'h1a5, vscroll: 8'h97, flip: 1'b0};
		wait_frame_start();

		write_and_check(REG_CTRL, 32'h0000_0001, 32'h0000_0001);
		wait_frame_start();
		exp_cfg.flip = 1'b1;
		wait_frame_start();  // one whole flipped frame

		$display("Test completed successfully");
		$finish;
	end

endmodule

/* filelist.f */
slap_video_pkg.sv
slap_video_regs.sv
slap_h_timing.sv
slap_v_timing.sv
slap_compositor.sv
slap_video_top.sv
tb_slap_video.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the video testbench with Verilator, verdict taken from the log
log=sim.log
rm -rf obj_dir "$log"
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_slap_video \
	-f filelist.f -o tb_slap_video > "$log" 2>&1 &&
	./obj_dir/tb_slap_video >> "$log" 2>&1 ||
	echo "Test failed" >> "$log"
cat "$log"
grep -q "Test failed" "$log" && exit 1 || exit 0
